//--- lcd_text_defines.svh
// LCD text geometry and character codes
// Shared by the package and by the text helper blocks of the front panel display

`ifndef LCD_TEXT_DEFINES_SVH
`define LCD_TEXT_DEFINES_SVH

// ====================
// Display geometry
// ====================

// Characters per line on the 2x16 panel
`define LCD_COLS 16

// Bits per character cell
`define LCD_CHAR_W 8

// ====================
// Character codes
// ====================

// Blank used for padding and cleared lines
`define CHR_SPACE 8'h20
// Filled progress cell
`define CHR_HASH 8'h23
// Empty progress cell
`define CHR_DASH 8'h2D
// Base for single decimal digits
`define CHR_ZERO 8'h30

// Full scale of the brew progress input
`define PCT_FULL 8'd100

`endif

//--- lcd_text_pkg.sv
// LCD text types shared by the message generator
// Line and character types, menu and selection encodings, machine status bundle

`include "lcd_text_defines.svh"

package lcd_text_pkg;

    typedef logic [`LCD_CHAR_W-1:0] lcd_char_t;
    // Leftmost character in the top byte
    typedef logic [`LCD_COLS*`LCD_CHAR_W-1:0] lcd_line_t;

    // Encoding fixed by the upstream navigator
    typedef enum logic [3:0] {
        SPLASH        = 4'd0,
        CHECK_ERRORS  = 4'd1,
        COFFEE_SELECT = 4'd2,
        DRINK_SELECT  = 4'd3,
        SIZE_SELECT   = 4'd4,
        CONFIRM       = 4'd5,
        BREWING       = 4'd6,
        COMPLETE      = 4'd7,
        SETTINGS      = 4'd8,
        ERROR         = 4'd9
    } menu_state_e;

    typedef enum logic [2:0] {
        BLACK     = 3'd0,
        CREAM     = 3'd1,
        LATTE     = 3'd2,
        MOCHA     = 3'd3,
        HOT_CHOCO = 3'd4
    } drink_e;

    typedef enum logic [1:0] {
        OZ8  = 2'd0,
        OZ12 = 2'd1,
        OZ16 = 2'd2
    } cup_size_e;

    // Zero selects bin 1, anything else bin 2
    typedef logic [2:0] coffee_bin_t;
    typedef logic [7:0] brew_pct_t;
    typedef logic [3:0] warn_count_t;

    typedef struct packed {
        coffee_bin_t coffee_bin;
        drink_e      drink;
        cup_size_e   size;
    } selection_t;

    typedef struct packed {
        logic bin0_empty;
        logic bin0_low;
        logic bin1_empty;
        logic bin1_low;
        logic paper_empty;
        logic temp_ready;
        logic pressure_ready;
    } machine_status_t;

    localparam lcd_line_t BLANK_LINE = {`LCD_COLS{`CHR_SPACE}};

    // Left-justify a right-aligned literal, dropping NUL bytes, pad with blanks
    function automatic lcd_line_t lcd_text(input lcd_line_t raw);
        lcd_line_t line;
        int        pos;
        line = BLANK_LINE;
        pos  = 0;
        for (int i = `LCD_COLS - 1; i >= 0; i--) begin
            if (raw[i*`LCD_CHAR_W +: `LCD_CHAR_W] != '0) begin
                line[(`LCD_COLS-1-pos)*`LCD_CHAR_W +: `LCD_CHAR_W] =
                    raw[i*`LCD_CHAR_W +: `LCD_CHAR_W];
                pos++;
            end
        end
        return line;
    endfunction

endpackage

//--- item_name_lookup.sv
// Selection label lookup
// Turns the chosen bin, drink and cup size into the padded texts of the
// select screens and the short drink and size line of the confirm screen

`timescale 1ns/1ps

`include "lcd_text_defines.svh"

module item_name_lookup (
    input  lcd_text_pkg::selection_t selection,
    output lcd_text_pkg::lcd_line_t  bin_label,
    output lcd_text_pkg::lcd_line_t  drink_label,
    output lcd_text_pkg::lcd_line_t  size_label,
    output lcd_text_pkg::lcd_line_t  confirm_label
);

    import lcd_text_pkg::*;

    // Short names, right-aligned, NUL filled
    logic [8*`LCD_CHAR_W-1:0] name_txt;
    logic [4*`LCD_CHAR_W-1:0] size_txt;
    logic                     drink_known;
    logic                     size_known;

    // Bin 1 only for code zero
    assign bin_label = (selection.coffee_bin == '0) ? lcd_text("Coffee: [1]")
                                                    : lcd_text("Coffee: [2]");

    // ====================
    // Drink names
    // ====================
    always_comb begin
        drink_known = 1'b1;
        name_txt    = "???";
        case (selection.drink)
            BLACK: begin
                name_txt    = "Black";
                drink_label = lcd_text("Drink: [Black]");
            end
            CREAM: begin
                name_txt    = "Cream";
                drink_label = lcd_text("Drink: [Cream]");
            end
            LATTE: begin
                name_txt    = "Latte";
                drink_label = lcd_text("Drink: [Latte]");
            end
            MOCHA: begin
                name_txt    = "Mocha";
                drink_label = lcd_text("Drink: [Mocha]");
            end
            HOT_CHOCO: begin
                // Closing bracket falls off the 16th column
                name_txt    = "HotChoco";
                drink_label = lcd_text("Drink: [HotChoco");
            end
            default: begin
                drink_known = 1'b0;
                drink_label = lcd_text("Drink: ?");
            end
        endcase
    end

    // ====================
    // Cup sizes
    // ====================
    always_comb begin
        size_known = 1'b1;
        case (selection.size)
            OZ8:  size_txt = "8oz";
            OZ12: size_txt = "12oz";
            OZ16: size_txt = "16oz";
            default: begin
                size_known = 1'b0;
                size_txt   = "?oz";
            end
        endcase
    end

    assign size_label = size_known ? lcd_text({"Size: [", size_txt, "]"})
                                   : lcd_text("Size: ?");

    // Name, blank, size; NUL gaps squeezed out by lcd_text
    assign confirm_label = drink_known ? lcd_text({name_txt, " ", size_txt})
                                       : lcd_text("??? ???");

endmodule

//--- progress_bar_gen.sv
// Brew progress bar
// Scales brew percent to a count of filled cells and draws the bar
// with '#' for filled and '-' for empty cells, filling from the left

`timescale 1ns/1ps

`include "lcd_text_defines.svh"

module progress_bar_gen (
    input  lcd_text_pkg::brew_pct_t brew_progress,
    output lcd_text_pkg::lcd_line_t bar_line
);

    import lcd_text_pkg::*;

    // Percent times column count, max 255*16
    logic [11:0] scaled;
    // Filled cells, 0..16
    logic [4:0]  filled;

    always_comb begin
        scaled = {4'd0, brew_progress} * 12'(`LCD_COLS);
        // Clamp at full scale and above
        if (brew_progress >= `PCT_FULL) begin
            filled = 5'(`LCD_COLS);
        end else begin
            // Floor of the scaled value over 100
            filled = 5'(scaled / 12'(`PCT_FULL));
        end
    end

    // ====================
    // Cell drawing
    // ====================
    always_comb begin
        for (int i = 0; i < `LCD_COLS; i++) begin
            // Cell 0 is the leftmost, top byte
            if (i < filled) begin
                bar_line[(`LCD_COLS-1-i)*`LCD_CHAR_W +: `LCD_CHAR_W] = `CHR_HASH;
            end else begin
                bar_line[(`LCD_COLS-1-i)*`LCD_CHAR_W +: `LCD_CHAR_W] = `CHR_DASH;
            end
        end
    end

endmodule

//--- fault_classifier.sv
// Machine status text
// Picks the highest priority fault for the error screen and builds
// the warning count or ready line for the splash screen

`timescale 1ns/1ps

`include "lcd_text_defines.svh"

module fault_classifier (
    input  lcd_text_pkg::machine_status_t status,
    input  lcd_text_pkg::warn_count_t     warning_count,
    output lcd_text_pkg::lcd_line_t       fault_line,
    output lcd_text_pkg::lcd_line_t       splash_line
);

    import lcd_text_pkg::*;

    // Single digit of the warning count
    lcd_char_t warn_digit;

    // ====================
    // Fault priority
    // ====================
    always_comb begin
        // Water heater first
        if (!status.temp_ready) begin
            fault_line = lcd_text("WATER TEMP!");
        end else if (!status.pressure_ready) begin
            fault_line = lcd_text("WATER ERROR!");
        end else if (status.paper_empty) begin
            fault_line = lcd_text("NO PAPER!");
        end else if (status.bin0_empty && status.bin1_empty) begin
            // One empty bin still lets the user pick the other
            fault_line = lcd_text("NO COFFEE!");
        end else begin
            fault_line = lcd_text("SYSTEM FAULT!");
        end
    end

    // ====================
    // Splash status
    // ====================

    // Counts above nine show a blank digit
    assign warn_digit = (warning_count <= 4'd9) ? (`CHR_ZERO + {4'd0, warning_count})
                                                : `CHR_SPACE;

    always_comb begin
        if (warning_count == '0) begin
            splash_line = lcd_text("Ready");
        end else begin
            // Digit lands in column 10
            splash_line = lcd_text({"Warnings: ", warn_digit});
        end
    end

endmodule

//--- screen_composer.sv
// Screen composer
// Selects the two next display lines for the current menu state from
// fixed prompts and the texts of the label, bar and fault helpers

`timescale 1ns/1ps

module screen_composer (
    input  lcd_text_pkg::menu_state_e menu_state,
    input  lcd_text_pkg::coffee_bin_t coffee_bin,
    input  logic                      bin0_empty,
    input  logic                      bin0_low,
    input  logic                      bin1_empty,
    input  logic                      bin1_low,
    input  lcd_text_pkg::lcd_line_t   bin_label,
    input  lcd_text_pkg::lcd_line_t   drink_label,
    input  lcd_text_pkg::lcd_line_t   size_label,
    input  lcd_text_pkg::lcd_line_t   confirm_label,
    input  lcd_text_pkg::lcd_line_t   bar_line,
    input  lcd_text_pkg::lcd_line_t   fault_line,
    input  lcd_text_pkg::lcd_line_t   splash_line,
    output lcd_text_pkg::lcd_line_t   next_line1,
    output lcd_text_pkg::lcd_line_t   next_line2
);

    import lcd_text_pkg::*;

    // Flags of the bin currently shown
    logic sel_empty;
    logic sel_low;

    // Bin 1 for code zero, else bin 2
    assign sel_empty = (coffee_bin == '0) ? bin0_empty : bin1_empty;
    assign sel_low   = (coffee_bin == '0) ? bin0_low   : bin1_low;

    always_comb begin
        case (menu_state)
            // ====================
            // Idle and startup
            // ====================
            SPLASH: begin
                next_line1 = lcd_text("Press Start");
                next_line2 = splash_line;
            end
            CHECK_ERRORS: begin
                next_line1 = lcd_text("Checking...");
                next_line2 = lcd_text("Please wait");
            end

            // ====================
            // Selection screens
            // ====================
            COFFEE_SELECT: begin
                next_line1 = bin_label;
                // Empty wins over low
                if (sel_empty) begin
                    next_line2 = lcd_text("Empty!");
                end else if (sel_low) begin
                    next_line2 = lcd_text("Low");
                end else begin
                    next_line2 = lcd_text("<-> Select");
                end
            end
            DRINK_SELECT: begin
                next_line1 = drink_label;
                next_line2 = lcd_text("<-> Select");
            end
            SIZE_SELECT: begin
                next_line1 = size_label;
                next_line2 = lcd_text("<-> Select");
            end
            CONFIRM: begin
                next_line1 = confirm_label;
                next_line2 = lcd_text("Start? Cancel?");
            end

            // ====================
            // Brew cycle
            // ====================
            BREWING: begin
                next_line1 = lcd_text("Brewing...");
                next_line2 = bar_line;
            end
            COMPLETE: begin
                next_line1 = lcd_text("Enjoy!");
                next_line2 = lcd_text("Press any key");
            end
            SETTINGS: begin
                next_line1 = lcd_text("Settings Mode");
                next_line2 = lcd_text("Cancel to exit");
            end
            ERROR: begin
                // Fault text already prioritized upstream
                next_line1 = fault_line;
                next_line2 = lcd_text("Fix & restart");
            end

            // Codes 10..15 from the navigator
            default: begin
                next_line1 = lcd_text("ERROR");
                next_line2 = BLANK_LINE;
            end
        endcase
    end

endmodule

//--- lcd_line_register.sv
// Display line register
// Holds both LCD lines and pulses message_updated on the cycle
// in which either registered line takes a new value

`timescale 1ns/1ps

module lcd_line_register (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lcd_text_pkg::lcd_line_t next_line1,
    input  lcd_text_pkg::lcd_line_t next_line2,
    output lcd_text_pkg::lcd_line_t line1_text,
    output lcd_text_pkg::lcd_line_t line2_text,
    output logic                    message_updated
);

    import lcd_text_pkg::*;

    // Incoming text differs from what is on screen
    logic text_change;

    assign text_change = (next_line1 != line1_text) || (next_line2 != line2_text);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Blank panel out of reset
            line1_text      <= BLANK_LINE;
            line2_text      <= BLANK_LINE;
            message_updated <= 1'b0;
        end else begin
            line1_text      <= next_line1;
            line2_text      <= next_line2;
            // Aligned with the new lines, high again on every further change
            message_updated <= text_change;
        end
    end

endmodule

//--- lcd_message_top.sv
// LCD message generator, top level
// Label, progress and fault helpers feed the screen composer,
// whose two lines are registered with a change pulse

`timescale 1ns/1ps

module lcd_message_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  lcd_text_pkg::menu_state_e     menu_state,
    input  lcd_text_pkg::selection_t      selection,
    input  lcd_text_pkg::brew_pct_t       brew_progress,
    input  lcd_text_pkg::warn_count_t     warning_count,
    input  lcd_text_pkg::machine_status_t status,
    output lcd_text_pkg::lcd_line_t       line1_text,
    output lcd_text_pkg::lcd_line_t       line2_text,
    output logic                          message_updated
);

    import lcd_text_pkg::*;

    // Helper texts into the composer
    lcd_line_t bin_label;
    lcd_line_t drink_label;
    lcd_line_t size_label;
    lcd_line_t confirm_label;
    lcd_line_t bar_line;
    lcd_line_t fault_line;
    lcd_line_t splash_line;
    // Composer to register
    lcd_line_t next_line1;
    lcd_line_t next_line2;

    // ====================
    // Text helpers
    // ====================
    item_name_lookup item_name_lookup_inst (
        .selection     (selection),
        .bin_label     (bin_label),
        .drink_label   (drink_label),
        .size_label    (size_label),
        .confirm_label (confirm_label)
    );

    progress_bar_gen progress_bar_gen_inst (
        .brew_progress (brew_progress),
        .bar_line      (bar_line)
    );

    fault_classifier fault_classifier_inst (
        .status        (status),
        .warning_count (warning_count),
        .fault_line    (fault_line),
        .splash_line   (splash_line)
    );

    // ====================
    // Screen select and output register
    // ====================
    screen_composer screen_composer_inst (
        .menu_state    (menu_state),
        .coffee_bin    (selection.coffee_bin),
        .bin0_empty    (status.bin0_empty),
        .bin0_low      (status.bin0_low),
        .bin1_empty    (status.bin1_empty),
        .bin1_low      (status.bin1_low),
        .bin_label     (bin_label),
        .drink_label   (drink_label),
        .size_label    (size_label),
        .confirm_label (confirm_label),
        .bar_line      (bar_line),
        .fault_line    (fault_line),
        .splash_line   (splash_line),
        .next_line1    (next_line1),
        .next_line2    (next_line2)
    );

    lcd_line_register lcd_line_register_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .next_line1      (next_line1),
        .next_line2      (next_line2),
        .line1_text      (line1_text),
        .line2_text      (line2_text),
        .message_updated (message_updated)
    );

endmodule

//--- lcd_message_asserts.sv
// Line register checks
// Reset values of the display lines and the change pulse behavior

`timescale 1ns/1ps

`include "lcd_text_defines.svh"

module lcd_message_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input lcd_text_pkg::lcd_line_t line1_text,
    input lcd_text_pkg::lcd_line_t line2_text,
    input logic                    message_updated
);

    int unsigned fail_count = 0;

    // Blank panel and no pulse after every edge taken under reset
    reset_values: assert property (@(posedge clk)
        !rst_n |=> (line1_text == {`LCD_COLS{`CHR_SPACE}}) &&
                   (line2_text == {`LCD_COLS{`CHR_SPACE}}) && !message_updated)
    else begin
        $error("line register not blank or pulse high during reset");
        fail_count++;
    end

    // Pulse only when a line took a new value at that edge
    pulse_needs_change: assert property (@(posedge clk) disable iff (!rst_n)
        message_updated |-> (line1_text != $past(line1_text)) ||
                            (line2_text != $past(line2_text)))
    else begin
        $error("message_updated high without a line change");
        fail_count++;
    end

    // Every change is flagged
    change_raises_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ((line1_text != $past(line1_text)) || (line2_text != $past(line2_text))) |->
            message_updated)
    else begin
        $error("line changed without message_updated");
        fail_count++;
    end

endmodule

bind lcd_line_register lcd_message_asserts line_asserts_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .line1_text      (line1_text),
    .line2_text      (line2_text),
    .message_updated (message_updated)
);

//--- tb_lcd_message.sv
// Testbench for the LCD message generator
// Applies a table of screens and a brew progress sweep, then checks
// both registered lines and the change pulse after every row

`timescale 1ns/1ps

`include "lcd_text_defines.svh"

module tb_lcd_message;

    import lcd_text_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int SWEEP_RANDOM = 32;
    // Status order: bin0 empty, bin0 low, bin1 empty, bin1 low, paper empty, temp ok, press ok
    localparam machine_status_t ST_OK = 7'b0000011;
    localparam selection_t      SEL0  = 8'h00;

    logic            clk;
    logic            rst_n;
    menu_state_e     menu_state;
    selection_t      selection;
    brew_pct_t       brew_progress;
    warn_count_t     warning_count;
    machine_status_t status;
    lcd_line_t       line1_text;
    lcd_line_t       line2_text;
    logic            message_updated;

    // ====================
    // Stimulus table
    // ====================
    logic [3:0]      row_state[$];
    selection_t      row_sel[$];
    brew_pct_t       row_pct[$];
    warn_count_t     row_warn[$];
    machine_status_t row_status[$];
    string           row_line1[$];
    string           row_line2[$];

    // Edge values of the bar, checked on purpose
    brew_pct_t   fixed_pct[5] = '{8'd0, 8'd6, 8'd7, 8'd99, 8'd100};
    int          tests;
    int          failed;
    int          errors;
    bit          table_ready;
    logic [31:0] rng;
    // Text currently on screen, for the pulse expectation
    lcd_line_t   prev_line1;
    lcd_line_t   prev_line2;

    lcd_message_top lcd_message_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .menu_state      (menu_state),
        .selection       (selection),
        .brew_progress   (brew_progress),
        .warning_count   (warning_count),
        .status          (status),
        .line1_text      (line1_text),
        .line2_text      (line2_text),
        .message_updated (message_updated)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Text to a 16 column line, leftmost char in the top byte, blank padded
    function automatic lcd_line_t to_line(input string s);
        lcd_line_t line;
        line = {`LCD_COLS{`CHR_SPACE}};
        for (int i = 0; i < `LCD_COLS; i++) begin
            if (i < s.len()) begin
                line[(`LCD_COLS-1-i)*`LCD_CHAR_W +: `LCD_CHAR_W] = s[i];
            end
        end
        return line;
    endfunction

    // Expected bar from the fill rule
    function automatic string bar_text(input brew_pct_t pct);
        string s;
        int    cells;
        s = "";
        if (pct >= 8'd100) begin
            cells = `LCD_COLS;
        end else begin
            cells = (int'(pct) * `LCD_COLS) / 100;
        end
        for (int i = 0; i < `LCD_COLS; i++) begin
            s = (i < cells) ? {s, "#"} : {s, "-"};
        end
        return s;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic selection_t sel_of(input logic [2:0] bin, input logic [2:0] drink,
                                          input logic [1:0] size);
        return {bin, drink, size};
    endfunction

    task automatic add_row(input logic [3:0] st, input selection_t sel, input string l1,
                           input string l2, input warn_count_t warn = 4'd0,
                           input machine_status_t ms = ST_OK, input brew_pct_t pct = 8'd0);
        row_state.push_back(st);
        row_sel.push_back(sel);
        row_pct.push_back(pct);
        row_warn.push_back(warn);
        row_status.push_back(ms);
        row_line1.push_back(l1);
        row_line2.push_back(l2);
    endtask

    task automatic build_table();
        brew_pct_t pct;
        // Same text as the idle screen, so no pulse
        add_row(SPLASH, SEL0, "Press Start", "Ready");
        add_row(SPLASH, SEL0, "Press Start", "Warnings: 1", 4'd1);
        add_row(SPLASH, SEL0, "Press Start", "Warnings: 9", 4'd9);
        add_row(SPLASH, SEL0, "Press Start", "Warnings:", 4'd12);
        add_row(CHECK_ERRORS, SEL0, "Checking...", "Please wait");
        add_row(COFFEE_SELECT, SEL0, "Coffee: [1]", "<-> Select");
        add_row(COFFEE_SELECT, SEL0, "Coffee: [1]", "Low", 4'd0, 7'b0100011);
        add_row(COFFEE_SELECT, SEL0, "Coffee: [1]", "Empty!", 4'd0, 7'b1100011);
        add_row(COFFEE_SELECT, sel_of(3'd3, 3'd0, 2'd0), "Coffee: [2]", "<-> Select",
                4'd0, 7'b1000011);
        add_row(COFFEE_SELECT, sel_of(3'd1, 3'd0, 2'd0), "Coffee: [2]", "Low", 4'd0, 7'b0001011);
        add_row(COFFEE_SELECT, sel_of(3'd7, 3'd0, 2'd0), "Coffee: [2]", "Empty!", 4'd0, 7'b0010011);
        add_row(DRINK_SELECT, sel_of(3'd0, 3'd0, 2'd0), "Drink: [Black]", "<-> Select");
        add_row(DRINK_SELECT, sel_of(3'd0, 3'd1, 2'd0), "Drink: [Cream]", "<-> Select");
        add_row(DRINK_SELECT, sel_of(3'd0, 3'd2, 2'd0), "Drink: [Latte]", "<-> Select");
        add_row(DRINK_SELECT, sel_of(3'd0, 3'd3, 2'd0), "Drink: [Mocha]", "<-> Select");
        add_row(DRINK_SELECT, sel_of(3'd0, 3'd4, 2'd0), "Drink: [HotChoco", "<-> Select");
        add_row(DRINK_SELECT, sel_of(3'd0, 3'd6, 2'd0), "Drink: ?", "<-> Select");
        // Only the size differs, screen text identical
        add_row(DRINK_SELECT, sel_of(3'd0, 3'd6, 2'd1), "Drink: ?", "<-> Select");
        add_row(SIZE_SELECT, sel_of(3'd0, 3'd0, 2'd0), "Size: [8oz]", "<-> Select");
        add_row(SIZE_SELECT, sel_of(3'd0, 3'd0, 2'd1), "Size: [12oz]", "<-> Select");
        add_row(SIZE_SELECT, sel_of(3'd0, 3'd0, 2'd2), "Size: [16oz]", "<-> Select");
        add_row(SIZE_SELECT, sel_of(3'd0, 3'd0, 2'd3), "Size: ?", "<-> Select");
        add_row(CONFIRM, sel_of(3'd0, 3'd3, 2'd1), "Mocha 12oz", "Start? Cancel?");
        add_row(CONFIRM, sel_of(3'd0, 3'd0, 2'd0), "Black 8oz", "Start? Cancel?");
        add_row(CONFIRM, sel_of(3'd0, 3'd4, 2'd2), "HotChoco 16oz", "Start? Cancel?");
        add_row(CONFIRM, sel_of(3'd0, 3'd2, 2'd3), "Latte ?oz", "Start? Cancel?");
        add_row(CONFIRM, sel_of(3'd0, 3'd5, 2'd1), "??? ???", "Start? Cancel?");
        add_row(COMPLETE, SEL0, "Enjoy!", "Press any key");
        add_row(SETTINGS, SEL0, "Settings Mode", "Cancel to exit");
        // Fault priority, several faults together first
        add_row(ERROR, SEL0, "WATER TEMP!", "Fix & restart", 4'd0, 7'b1010100);
        add_row(ERROR, SEL0, "WATER ERROR!", "Fix & restart", 4'd0, 7'b1010110);
        add_row(ERROR, SEL0, "NO PAPER!", "Fix & restart", 4'd0, 7'b1010111);
        add_row(ERROR, SEL0, "NO COFFEE!", "Fix & restart", 4'd0, 7'b1010011);
        add_row(ERROR, SEL0, "SYSTEM FAULT!", "Fix & restart", 4'd0, 7'b1000011);
        add_row(ERROR, SEL0, "SYSTEM FAULT!", "Fix & restart");
        add_row(4'd12, SEL0, "ERROR", "");
        add_row(4'd15, SEL0, "ERROR", "");
        // Brew sweep, fixed edge values then random ones
        for (int i = 0; i < 5 + SWEEP_RANDOM; i++) begin
            if (i < 5) begin
                pct = fixed_pct[i];
            end else begin
                rng = xorshift32(rng);
                pct = rng[7:0];
            end
            add_row(BREWING, SEL0, "Brewing...", bar_text(pct), 4'd0, ST_OK, pct);
        end
    endtask

    task automatic run_row(input int i);
        lcd_line_t exp1;
        lcd_line_t exp2;
        logic      exp_upd;
        int        errs_before;
        exp1        = to_line(row_line1[i]);
        exp2        = to_line(row_line2[i]);
        exp_upd     = (exp1 != prev_line1) || (exp2 != prev_line2);
        errs_before = errors;
        @(posedge clk);
        menu_state    <= menu_state_e'(row_state[i]);
        selection     <= row_sel[i];
        brew_progress <= row_pct[i];
        warning_count <= row_warn[i];
        status        <= row_status[i];
        // New lines on the next edge, sampled mid-cycle
        @(posedge clk);
        @(negedge clk);
        if (line1_text !== exp1) begin
            $display("ERROR row %0d line1_text: got %h expected %h", i, line1_text, exp1);
            errors++;
        end
        if (line2_text !== exp2) begin
            $display("ERROR row %0d line2_text: got %h expected %h", i, line2_text, exp2);
            errors++;
        end
        if (message_updated !== exp_upd) begin
            $display("ERROR row %0d message_updated: got %h expected %h",
                     i, message_updated, exp_upd);
            errors++;
        end
        // Inputs held, so the pulse drops
        @(posedge clk);
        @(negedge clk);
        if (message_updated !== 1'b0) begin
            $display("ERROR row %0d message_updated (held): got %h expected 0", i, message_updated);
            errors++;
        end
        prev_line1 = exp1;
        prev_line2 = exp2;
        tests++;
        if (errors == errs_before) begin
            $display("row %0d ok: [%s] [%s]", i, row_line1[i], row_line2[i]);
        end else begin
            failed++;
            $display("row %0d FAIL: [%s] [%s]", i, row_line1[i], row_line2[i]);
        end
    endtask

    // ====================
    // Watchdog
    // ====================
    initial begin
        int limit;
        wait (table_ready);
        limit = ((row_state.size() + 1) * 4 + RESET_CYCLES + 50) * CLK_PERIOD;
        #(limit);
        $display("Timeout: run did not finish within %0d ns", limit);
        $display("Errors found");
        $finish;
    end

    initial begin
        int asrt_fails;
        rst_n         = 1'b0;
        menu_state    = SPLASH;
        selection     = SEL0;
        brew_progress = '0;
        warning_count = '0;
        status        = ST_OK;
        tests         = 0;
        failed        = 0;
        errors        = 0;
        rng           = 32'ha8d2_b691;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // Still the reset values right after release
        @(negedge clk);
        tests++;
        if (line1_text !== to_line("") || line2_text !== to_line("") || message_updated !== 1'b0) begin
            $display("ERROR reset line1_text %h line2_text %h message_updated %h",
                     line1_text, line2_text, message_updated);
            errors++;
            failed++;
            $display("reset FAIL");
        end else begin
            $display("reset ok");
        end
        // Idle splash screen loads from the initial inputs
        @(posedge clk);
        @(negedge clk);
        prev_line1 = to_line("Press Start");
        prev_line2 = to_line("Ready");
        for (int i = 0; i < row_state.size(); i++) begin
            run_row(i);
        end
        asrt_fails = int'(lcd_message_inst.lcd_line_register_inst.line_asserts_inst.fail_count);
        $display("Summary: %0d tests, %0d failed, %0d check mismatches, %0d assertion failures",
                 tests, failed, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
lcd_text_pkg.sv
item_name_lookup.sv
progress_bar_gen.sv
fault_classifier.sv
screen_composer.sv
lcd_line_register.sv
lcd_message_top.sv
lcd_message_asserts.sv
tb_lcd_message.sv

//--- Makefile
# Verilator build and run of the LCD message generator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_lcd_message
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; \
	else echo "Simulation PASSED"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
